// ==== include/mem_subsys_config.svh ====
// Memory subsystem configuration
`ifndef MEM_SUBSYS_CONFIG_SVH
`define MEM_SUBSYS_CONFIG_SVH

// Word address and data widths
`define MEM_ADDR_W 12
`define MEM_DATA_W 16

// Burst shape and memory read pipeline depth
`define MEM_BURST 8
`define MEM_LATENCY 2

// Arbiter ports
`define MEM_CLIENTS 2

// Shared region, burst aligned
`define REGION_BASE 12'h100
`define REGION_WORDS 64

// Display FIFO
`define FETCH_DEPTH 16

`endif

// ==== hw/mem_pkg.sv ====
// Memory subsystem types
`include "mem_subsys_config.svh"

package mem_pkg;

// Display view of a memory word
typedef struct packed {
	logic [4:0] red;
	logic [5:0] green;
	logic [4:0] blue;
} rgb565_t;

// The tester sees raw data, the display sees colour fields
typedef union packed {
	logic [`MEM_DATA_W-1:0] raw;
	rgb565_t rgb;
} mem_word_u;

// Client to arbiter
typedef struct packed {
	logic req;
	logic wr;
	logic [`MEM_ADDR_W-1:0] addr;
	mem_word_u wdata;
} mem_req_t;

// Arbiter to client
typedef struct packed {
	logic ack;
	logic valid;
	mem_word_u rdata;
} mem_rsp_t;

// Arbiter to memory, one word per cycle
typedef struct packed {
	logic en;
	logic wr;
	logic [`MEM_ADDR_W-1:0] addr;
	mem_word_u wdata;
} mem_cmd_t;

typedef struct packed {
	mem_word_u pix;
	logic sof;
} pixel_t;

// Arbiter port assignment
localparam int CL_TESTER = 0;
localparam int CL_FETCH = 1;

endpackage

// ==== hw/mem_arbiter.sv ====
// Round-robin burst arbiter
`timescale 1ns/1ps
`include "mem_subsys_config.svh"

module mem_arbiter import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst,
	input mem_req_t client_req [`MEM_CLIENTS],
	output mem_rsp_t client_rsp [`MEM_CLIENTS],
	output mem_cmd_t cmd,
	input mem_word_u rdata,
	input logic rvalid
);

localparam int N = `MEM_CLIENTS;
localparam int AW = `MEM_ADDR_W;
localparam int BURST = `MEM_BURST;
localparam int CW = $clog2(BURST);
localparam int IW = (N > 1) ? $clog2(N) : 1;
localparam int OW = $clog2(BURST + 1);

logic active;
logic wr_q;
logic [IW-1:0] owner;
logic [IW-1:0] prio;
logic [IW-1:0] gnt_idx;
logic gnt_found;
logic [CW-1:0] cnt;
logic [AW-1:0] base;
logic [OW-1:0] rd_out;
logic [N-1:0] ack_vec;
logic [N-1:0] valid_q;
mem_word_u rdata_q;
logic idle;
logic last_cmd;
logic issue_rd;

// Idle only once the last read word has come back
assign idle = !active && (rd_out == '0);
assign last_cmd = active && (cnt == CW'(BURST - 1));
assign issue_rd = active && !wr_q;

// Search starts at the client after the one last served
always_comb begin
	int idx;
	gnt_found = 1'b0;
	gnt_idx = prio;
	for (int k = 0; k < N; k++) begin
		idx = int'(prio) + k;
		if (idx >= N)
			idx = idx - N;
		if (!gnt_found && client_req[idx].req) begin
			gnt_found = 1'b1;
			gnt_idx = IW'(idx);
		end
	end
end

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		active <= 1'b0;
		owner <= '0;
		prio <= '0;
		cnt <= '0;
		rd_out <= '0;
		valid_q <= '0;
	end else begin
		if (idle && gnt_found) begin
			active <= 1'b1;
			owner <= gnt_idx;
			cnt <= '0;
			prio <= (gnt_idx == IW'(N - 1)) ? '0 : gnt_idx + 1'b1;
		end else if (active) begin
			cnt <= cnt + 1'b1;
			if (last_cmd)
				active <= 1'b0;
		end
		rd_out <= rd_out + OW'(issue_rd) - OW'(rvalid);
		for (int i = 0; i < N; i++)
			valid_q[i] <= rvalid && (owner == IW'(i));
	end
end

// Burst parameters latched at grant
always_ff @(posedge CLOCK_50) begin
	if (idle && gnt_found) begin
		base <= client_req[gnt_idx].addr;
		wr_q <= client_req[gnt_idx].wr;
	end
	rdata_q <= rdata;
end

// Writes ack every word, reads only the first
always_comb begin
	for (int i = 0; i < N; i++)
		ack_vec[i] = active && (owner == IW'(i)) && (wr_q || cnt == '0);
end

always_comb begin
	cmd.en = active;
	cmd.wr = wr_q;
	cmd.addr = base + AW'(cnt);
	cmd.wdata = client_req[owner].wdata;
end

always_comb begin
	for (int i = 0; i < N; i++) begin
		client_rsp[i].ack = ack_vec[i];
		client_rsp[i].valid = valid_q[i];
		client_rsp[i].rdata = rdata_q;
	end
end

// Only the owner hears from the arbiter, even across a burst handover
assert property (@(posedge CLOCK_50) disable iff (rst) $onehot0(ack_vec | valid_q))
	else $error("ack or valid sent to more than one client");

endmodule

// ==== hw/burst_mem.sv ====
// On-chip burst word memory
`timescale 1ns/1ps
`include "mem_subsys_config.svh"

module burst_mem import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst,
	input mem_cmd_t cmd,
	output mem_word_u rdata,
	output logic rvalid
);

localparam int AW = `MEM_ADDR_W;
localparam int LAT = `MEM_LATENCY;

// Contents are undefined until first written
mem_word_u mem [2**AW];

// Read pipeline, one stage per cycle of latency
mem_word_u data_q [LAT];
logic [LAT-1:0] valid_q;

always_ff @(posedge CLOCK_50) begin
	if (cmd.en && cmd.wr)
		mem[cmd.addr] <= cmd.wdata;
end

// First stage is the array read itself
always_ff @(posedge CLOCK_50) begin
	if (cmd.en && !cmd.wr)
		data_q[0] <= mem[cmd.addr];
	for (int s = 1; s < LAT; s++)
		data_q[s] <= data_q[s - 1];
end

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		valid_q <= '0;
	end else begin
		valid_q[0] <= cmd.en && !cmd.wr;
		for (int s = 1; s < LAT; s++)
			valid_q[s] <= valid_q[s - 1];
	end
end

assign rdata = data_q[LAT-1];
assign rvalid = valid_q[LAT-1];

// The arbiter must never issue to an unknown address
assert property (@(posedge CLOCK_50) disable iff (rst) cmd.en |-> !$isunknown(cmd.addr))
	else $error("memory command with unknown address");

endmodule

// ==== hw/frame_fetch.sv ====
// Display fetch engine
`timescale 1ns/1ps
`include "mem_subsys_config.svh"

module frame_fetch import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst,
	input logic scan_en,
	output mem_req_t req,
	input mem_rsp_t rsp,
	output pixel_t pixel,
	output logic pix_valid,
	input logic pix_ready
);

localparam int AW = `MEM_ADDR_W;
localparam int BURST = `MEM_BURST;
localparam int DEPTH = `FETCH_DEPTH;
localparam int WORDS = `REGION_WORDS;
localparam int PW = $clog2(DEPTH);
localparam int CNTW = $clog2(DEPTH + 1);
localparam int OFFW = $clog2(WORDS);
localparam logic [AW-1:0] BASE = `REGION_BASE;

mem_word_u fifo [DEPTH];
mem_word_u head;
logic [PW-1:0] wptr;
logic [PW-1:0] rptr;
logic [CNTW-1:0] count;
logic [CNTW-1:0] outstanding;
logic [CNTW:0] committed;
logic [OFFW-1:0] burst_off;
logic [OFFW-1:0] rd_off;
logic req_q;
logic raise;
logic push;
logic pop;

// Words queued plus words promised by requested bursts
assign committed = {1'b0, count} + {1'b0, outstanding};
assign raise = scan_en && !req_q && (int'(committed) < DEPTH - BURST);
assign push = rsp.valid;
assign pix_valid = (count != '0);
assign pop = pix_valid && pix_ready;

always_comb begin
	req.req = req_q;
	req.wr = 1'b0;
	req.addr = BASE + AW'(burst_off);
	req.wdata = '0;
end

// Burst requests walk the region in order and wrap
always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		req_q <= 1'b0;
		burst_off <= '0;
		outstanding <= '0;
	end else begin
		if (raise) begin
			req_q <= 1'b1;
		end else if (req_q && rsp.ack) begin
			req_q <= 1'b0;
			burst_off <= (burst_off == OFFW'(WORDS - BURST)) ? '0 : burst_off + OFFW'(BURST);
		end
		outstanding <= outstanding + (raise ? CNTW'(BURST) : '0) - CNTW'(push);
	end
end

always_ff @(posedge CLOCK_50) begin
	if (push)
		fifo[wptr] <= rsp.rdata;
end

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		wptr <= '0;
		rptr <= '0;
		count <= '0;
		rd_off <= '0;
	end else begin
		if (push)
			wptr <= (wptr == PW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
		if (pop) begin
			rptr <= (rptr == PW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
			rd_off <= (rd_off == OFFW'(WORDS - 1)) ? '0 : rd_off + 1'b1;
		end
		count <= count + CNTW'(push) - CNTW'(pop);
	end
end

// Head word handed out as colour fields
assign head = fifo[rptr];

always_comb begin
	pixel.pix.rgb.red = head.rgb.red;
	pixel.pix.rgb.green = head.rgb.green;
	pixel.pix.rgb.blue = head.rgb.blue;
	pixel.sof = (rd_off == '0);
end

// Credit counting keeps the arbiter's read data from overrunning the queue
assert property (@(posedge CLOCK_50) disable iff (rst) push |-> (int'(count) != DEPTH))
	else $error("display FIFO written while full");

endmodule

// ==== hw/mem_tester.sv ====
// Memory self-test client
`timescale 1ns/1ps
`include "mem_subsys_config.svh"

module mem_tester import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst,
	input logic start,
	input logic fault,
	input logic [`MEM_DATA_W-1:0] key,
	output mem_req_t req,
	input mem_rsp_t rsp,
	output logic busy,
	output logic done,
	output logic fail
);

localparam int AW = `MEM_ADDR_W;
localparam int DW = `MEM_DATA_W;
localparam int BURST = `MEM_BURST;
localparam int WORDS = `REGION_WORDS;
localparam int CW = $clog2(BURST);
localparam int OFFW = $clog2(WORDS);
localparam logic [AW-1:0] BASE = `REGION_BASE;

typedef enum logic [2:0] {
	S_IDLE,
	S_WR_GO,
	S_WR,
	S_RD_GO,
	S_RD,
	S_RD_DATA
} state_t;

state_t state;
logic req_q;
logic [OFFW-1:0] burst_off;
logic [CW-1:0] word;
logic [DW-1:0] key_q;
logic fault_q;
mem_word_u wdata_q;
logic [AW-1:0] burst_addr;
logic [AW-1:0] word_addr;
logic [DW-1:0] expected;
logic last_word;
logic last_burst;

// Test pattern, address XOR key
function automatic logic [DW-1:0] pattern(input logic [AW-1:0] a, input logic [DW-1:0] k);
	return DW'(a) ^ k;
endfunction

assign burst_addr = BASE + AW'(burst_off);
assign word_addr = burst_addr + AW'(word);
assign expected = pattern(word_addr, key_q);
assign last_word = (word == CW'(BURST - 1));
assign last_burst = (burst_off == OFFW'(WORDS - BURST));

always_comb begin
	req.req = req_q;
	req.wr = (state == S_WR);
	req.addr = burst_addr;
	req.wdata = wdata_q;
end

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= S_IDLE;
		req_q <= 1'b0;
		burst_off <= '0;
		word <= '0;
		busy <= 1'b0;
		done <= 1'b0;
		fail <= 1'b0;
	end else begin
		done <= 1'b0;
		case (state)
		S_IDLE:
			if (start) begin
				busy <= 1'b1;
				fail <= 1'b0;
				burst_off <= '0;
				state <= S_WR_GO;
			end
		S_WR_GO: begin
			req_q <= 1'b1;
			word <= '0;
			state <= S_WR;
		end
		S_WR:
			if (rsp.ack) begin
				word <= word + 1'b1;
				if (last_word) begin
					req_q <= 1'b0;
					burst_off <= last_burst ? '0 : burst_off + OFFW'(BURST);
					state <= last_burst ? S_RD_GO : S_WR_GO;
				end
			end
		S_RD_GO: begin
			req_q <= 1'b1;
			word <= '0;
			state <= S_RD;
		end
		S_RD:
			if (rsp.ack) begin
				req_q <= 1'b0;
				state <= S_RD_DATA;
			end
		S_RD_DATA:
			if (rsp.valid) begin
				word <= word + 1'b1;
				if (rsp.rdata.raw != expected)
					fail <= 1'b1;
				if (last_word) begin
					if (last_burst) begin
						busy <= 1'b0;
						done <= 1'b1;
						burst_off <= '0;
						state <= S_IDLE;
					end else begin
						burst_off <= burst_off + OFFW'(BURST);
						state <= S_RD_GO;
					end
				end
			end
		default: state <= S_IDLE;
		endcase
	end
end

// Key and fault hold for the whole run
always_ff @(posedge CLOCK_50) begin
	if (state == S_IDLE && start) begin
		key_q <= key;
		fault_q <= fault;
	end
	// First word of a burst is the faulted one
	if (state == S_WR_GO)
		wdata_q.raw <= pattern(burst_addr, key_q) ^ {DW{fault_q}};
	else if (state == S_WR && rsp.ack)
		wdata_q.raw <= pattern(word_addr + 1'b1, key_q);
end

endmodule

// ==== hw/mem_subsys_top.sv ====
// Shared memory subsystem top
`timescale 1ns/1ps
`include "mem_subsys_config.svh"

module mem_subsys_top import mem_pkg::*; (
	input logic CLOCK_50,
	input logic rst,
	input logic start,
	input logic fault,
	input logic scan_en,
	input logic pix_ready,
	input logic [`MEM_DATA_W-1:0] key,
	output logic busy,
	output logic done,
	output logic fail,
	output logic pix_valid,
	output pixel_t pixel
);

// Client ports of the arbiter
mem_req_t client_req [`MEM_CLIENTS];
mem_rsp_t client_rsp [`MEM_CLIENTS];

// Arbiter to memory
mem_cmd_t cmd;
mem_word_u rdata;
logic rvalid;

// Self-test client
mem_tester u_tester (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.start(start),
	.fault(fault),
	.key(key),
	.req(client_req[CL_TESTER]),
	.rsp(client_rsp[CL_TESTER]),
	.busy(busy),
	.done(done),
	.fail(fail)
);

// Display client
frame_fetch u_fetch (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.scan_en(scan_en),
	.req(client_req[CL_FETCH]),
	.rsp(client_rsp[CL_FETCH]),
	.pixel(pixel),
	.pix_valid(pix_valid),
	.pix_ready(pix_ready)
);

mem_arbiter u_arb (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.client_req(client_req),
	.client_rsp(client_rsp),
	.cmd(cmd),
	.rdata(rdata),
	.rvalid(rvalid)
);

burst_mem u_mem (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.cmd(cmd),
	.rdata(rdata),
	.rvalid(rvalid)
);

endmodule

// ==== verification/tb_mem_subsys.sv ====
// Memory subsystem testbench
`timescale 1ns/1ps
`include "mem_subsys_config.svh"

module tb_mem_subsys import mem_pkg::*; ();

localparam int K_RUN = 0;
localparam int K_SCAN_RUN = 1;
localparam int K_PIXELS = 2;

// One parsed trace line
typedef struct packed {
	logic [1:0] kind;
	logic [15:0] key;
	logic fault;
	logic exp_fail;
	logic [15:0] count;
	logic rand_ready;
} trace_entry_t;

logic CLOCK_50;
logic rst;
logic start;
logic fault;
logic scan_en;
logic pix_ready;
logic [`MEM_DATA_W-1:0] key;
logic busy;
logic done;
logic fail;
logic pix_valid;
pixel_t pixel;

// Values applied at the next rising edge
logic nxt_start;
logic nxt_fault;
logic nxt_scan;
logic nxt_ready;
logic [15:0] nxt_key;

// Pattern of the most recent test run
logic [15:0] last_key;
logic last_fault;

integer seed = 32'h7ac9_3a1c;
int cur_off;
bit trace_loaded;
trace_entry_t trace_q [$];

mem_subsys_top u_dut (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.start(start),
	.fault(fault),
	.scan_en(scan_en),
	.pix_ready(pix_ready),
	.key(key),
	.busy(busy),
	.done(done),
	.fail(fail),
	.pix_valid(pix_valid),
	.pixel(pixel)
);

initial begin
	CLOCK_50 = 1'b0;
	forever #2 CLOCK_50 = ~CLOCK_50;
end

task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp) begin
		$display("[FAIL] time %0t: %s, got %0h, expected %0h", $time, what, got, exp);
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopping at first mismatch");
	end
endtask

// Address XOR key, first word of each burst inverted after a faulted fill
function automatic logic [15:0] expected_pixel(input int off);
	logic [15:0] v;
	v = 16'(`REGION_BASE + off) ^ last_key;
	if (last_fault && (off % `MEM_BURST == 0))
		v = ~v;
	return v;
endfunction

task automatic check_pixel(input pixel_t seen, input int off);
	check_value(seen.pix.raw, expected_pixel(off), $sformatf("pixel at offset %0d", off));
	check_value(seen.sof, (off == 0), $sformatf("sof at offset %0d", off));
endtask

// One clock cycle; a pixel counts when valid and ready meet at the falling edge
task automatic tick(input logic rand_ready, output logic took, output pixel_t seen,
		output int seen_off);
	logic [31:0] rnd;
	@(posedge CLOCK_50);
	if (rand_ready) begin
		rnd = $random(seed);
		pix_ready <= rnd[0];
	end else begin
		pix_ready <= nxt_ready;
	end
	start <= nxt_start;
	fault <= nxt_fault;
	key <= nxt_key;
	scan_en <= nxt_scan;
	@(negedge CLOCK_50);
	took = pix_valid && pix_ready;
	seen = pixel;
	seen_off = cur_off;
	if (took)
		cur_off = (cur_off + 1) % `REGION_WORDS;
endtask

// Stop scanning and empty the display FIFO
task automatic drain(input bit check_px);
	int quiet;
	logic took;
	pixel_t seen;
	int seen_off;
	nxt_scan = 1'b0;
	nxt_ready = 1'b1;
	quiet = 0;
	while (quiet < 32) begin
		tick(1'b0, took, seen, seen_off);
		if (took && check_px)
			check_pixel(seen, seen_off);
		if (pix_valid)
			quiet = 0;
		else
			quiet++;
	end
	nxt_ready = 1'b0;
endtask

task automatic run_test(input logic [15:0] k, input logic f, input logic exp_fail,
		input bit with_scan);
	logic took;
	pixel_t seen;
	int seen_off;
	int px_count;
	nxt_key = k;
	nxt_fault = f;
	nxt_scan = with_scan;
	nxt_ready = 1'b0;
	nxt_start = 1'b1;
	tick(1'b0, took, seen, seen_off);
	nxt_start = 1'b0;
	nxt_ready = with_scan;
	tick(1'b0, took, seen, seen_off);
	check_value(busy, 1'b1, "busy after start");
	check_value(fail, 1'b0, "fail cleared on start");
	// Pixels while the tester runs are only counted
	px_count = 0;
	do begin
		tick(1'b0, took, seen, seen_off);
		if (took)
			px_count++;
	end while (done !== 1'b1);
	check_value(fail, exp_fail, $sformatf("fail after run with key %h", k));
	check_value(busy, 1'b0, "busy at done");
	if (with_scan)
		check_value(px_count > 0, 1'b1, "pixels delivered during the test run");
	last_key = k;
	last_fault = f;
	if (with_scan)
		drain(1'b0);
endtask

task automatic scan_pixels(input int count, input logic rand_mode);
	int got;
	logic took;
	pixel_t seen;
	int seen_off;
	nxt_scan = 1'b1;
	nxt_ready = 1'b1;
	got = 0;
	while (got < count) begin
		tick(rand_mode, took, seen, seen_off);
		if (took) begin
			check_pixel(seen, seen_off);
			got++;
		end
	end
	drain(1'b1);
endtask

task automatic load_trace();
	int fd;
	int code;
	string tok;
	string rest;
	logic [15:0] k;
	int f;
	int e;
	trace_entry_t ent;
	fd = $fopen("verification/mem_subsys_trace.txt", "r");
	if (fd == 0) begin
		$display("Could not open the trace file verification/mem_subsys_trace.txt");
		$display("*** TEST FAILED ***");
		$fatal(1, "Missing trace file");
	end
	while (!$feof(fd)) begin
		code = $fscanf(fd, "%s", tok);
		if (code != 1)
			break;
		ent = '0;
		if (tok[0] == "#") begin
			code = $fgets(rest, fd);
		end else if (tok == "run" || tok == "scan_run") begin
			code = $fscanf(fd, "%h %d %d", k, f, e);
			ent.kind = (tok == "run") ? 2'(K_RUN) : 2'(K_SCAN_RUN);
			ent.key = k;
			ent.fault = f[0];
			ent.exp_fail = e[0];
			trace_q.push_back(ent);
		end else if (tok == "pixels") begin
			code = $fscanf(fd, "%d %d", f, e);
			ent.kind = 2'(K_PIXELS);
			ent.count = 16'(f);
			ent.rand_ready = e[0];
			trace_q.push_back(ent);
		end else begin
			$display("Unknown entry '%s' in the trace file", tok);
			$display("*** TEST FAILED ***");
			$fatal(1, "Bad trace file");
		end
	end
	$fclose(fd);
	trace_loaded = 1'b1;
endtask

// Watchdog scaled by the trace length
initial begin
	int limit;
	wait (trace_loaded);
	limit = trace_q.size() * `REGION_WORDS * 40;
	repeat (limit) @(posedge CLOCK_50);
	$display("Run timed out after %0d cycles without finishing the trace", limit);
	$display("*** TEST FAILED ***");
	$fatal(1, "Timeout");
end

initial begin
	trace_entry_t ent;
	rst = 1'b1;
	start = 1'b0;
	fault = 1'b0;
	scan_en = 1'b0;
	pix_ready = 1'b0;
	key = '0;
	nxt_start = 1'b0;
	nxt_fault = 1'b0;
	nxt_scan = 1'b0;
	nxt_ready = 1'b0;
	nxt_key = '0;
	last_key = '0;
	last_fault = 1'b0;
	cur_off = 0;
	trace_loaded = 1'b0;
	load_trace();
	repeat (3) @(posedge CLOCK_50);
	rst <= 1'b0;
	@(negedge CLOCK_50);
	check_value(pix_valid, 1'b0, "pix_valid after reset");
	check_value(busy, 1'b0, "busy after reset");
	check_value(done, 1'b0, "done after reset");
	check_value(fail, 1'b0, "fail after reset");
	for (int idx = 0; idx < trace_q.size(); idx++) begin
		ent = trace_q[idx];
		case (int'(ent.kind))
		K_RUN:
			run_test(ent.key, ent.fault, ent.exp_fail, 1'b0);
		K_SCAN_RUN:
			run_test(ent.key, ent.fault, ent.exp_fail, 1'b1);
		default:
			scan_pixels(int'(ent.count), ent.rand_ready);
		endcase
	end
	$display("*** TEST PASSED ***");
	$finish;
end

endmodule

// ==== verilog.f ====
+incdir+include
hw/mem_pkg.sv
hw/mem_arbiter.sv
hw/burst_mem.sv
hw/frame_fetch.sv
hw/mem_tester.sv
hw/mem_subsys_top.sv
verification/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/mem_pkg.sv
      - hw/mem_arbiter.sv
      - hw/burst_mem.sv
      - hw/frame_fetch.sv
      - hw/mem_tester.sv
      - hw/mem_subsys_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/tb_mem_subsys.sv

// ==== verification/mem_subsys_trace.txt ====
# run|scan_run <key hex> <fault> <expect fail>
# pixels <count> <ready mode, 0 always high, 1 random>
run a5c3 0 0
pixels 150 0
run 1234 0 0
run 0ff0 0 0
pixels 100 1
# Faulted fill, then a clean run clears fail
run 0ff0 1 1
pixels 140 0
pixels 90 1
run 5a5a 0 0
pixels 70 0
# Tester and display sharing the memory
scan_run 3c3c 0 0
pixels 80 0
scan_run 7e81 1 1
pixels 130 1
run ffff 0 0
pixels 64 0
run 0000 1 1
pixels 100 1
